// ==== dv/lcd_debug_tb.sv ====
`default_nettype none

module lcd_debug_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic        ram_view;
		logic [7:0]  addr;
		logic [7:0]  data;
		logic [3:0]  sel;
		logic [7:0]  val;  // Byte placed at reg_sel
		logic [63:0] text; // Expected line
	} row_t;

	localparam int ROWS = 9;

	logic        qzt_clk;
	logic        reset;
	logic        ram_view;
	logic [7:0]  mem_addr;
	logic [7:0]  mem_data;
	logic [95:0] cpu_regs;
	logic [3:0]  reg_sel;
	wire         lcd_rs;
	wire         lcd_e;
	wire  [3:0]  lcd_data;
	row_t        rows [ROWS];
	int          seed;
	bit          timed_out;

	lcd_debug_top #(
		.STEP(2), .HOLD(24), .POWER_ON(40), .WAKE(30), .CLEAR(30), .FRAME(20)
	) uut (
		.qzt_clk(qzt_clk), .reset(reset), .ram_view(ram_view), .mem_addr(mem_addr),
		.mem_data(mem_data), .cpu_regs(cpu_regs), .reg_sel(reg_sel),
		.lcd_rs(lcd_rs), .lcd_e(lcd_e), .lcd_data(lcd_data)
	);

	lcd_monitor mon (
		.qzt_clk(qzt_clk), .reset(reset), .lcd_rs(lcd_rs), .lcd_e(lcd_e), .lcd_data(lcd_data)
	);

	initial begin
		qzt_clk = 1'b0;
		forever #20 qzt_clk = ~qzt_clk;
	end

	// Registers other than the selected one get random bytes
	task automatic apply_row(input row_t r);
		int rnd;
		ram_view = r.ram_view;
		mem_addr = r.addr;
		mem_data = r.data;
		reg_sel  = r.sel;
		for (int i = 0; i < 12; i++) begin
			rnd = $random(seed);
			cpu_regs[i*8 +: 8] = (i == r.sel) ? r.val : rnd[7:0];
		end
	endtask

	initial begin
		seed      = 73555;
		timed_out = 1'b0;
		reset     = 1'b1;
		ram_view  = 1'b0;
		mem_addr  = 8'h00;
		mem_data  = 8'h00;
		cpu_regs  = '0;
		reg_sel   = 4'd0;
		rows[0] = {1'b1, 8'h3F, 8'hA7, 4'd0, 8'h00, "RM 3F A7"};
		rows[1] = {1'b1, 8'h90, 8'h0B, 4'd0, 8'h00, "RM 90 0B"}; // Digits around 9
		rows[2] = {1'b0, 8'h00, 8'h00, 4'd0, 8'h5C, "PC PC 5C"};
		rows[3] = {1'b0, 8'h00, 8'h00, 4'd3, 8'hE1, "PC W  E1"};
		rows[4] = {1'b1, 8'h00, 8'hFF, 4'd3, 8'h00, "RM 00 FF"};
		rows[5] = {1'b0, 8'h00, 8'h00, 4'd8, 8'h9A, "PC SP 9A"};
		rows[6] = {1'b0, 8'h00, 8'h00, 4'd11, 8'h40, "PC DI 40"};
		rows[7] = {1'b0, 8'h00, 8'h00, 4'd13, 8'h00, "PC    00"}; // Out of range
		rows[8] = {1'b0, 8'h00, 8'h00, 4'd5, 8'h0F, "PC A  0F"};
		repeat (2) @(negedge qzt_clk);
		mon.check_idle("pins idle during reset");
		reset = 1'b0;
		@(negedge qzt_clk);
		mon.check_idle("pins idle in first cycle after reset");
		mon.check_startup(timed_out);
		for (int i = 0; i < ROWS && !timed_out; i++) begin
			@(negedge qzt_clk);
			apply_row(rows[i]);
			mon.check_frame(rows[i].text, $sformatf("row %0d", i), timed_out);
		end
		$display("Tests passed: %0d, failed: %0d", mon.pass_cnt, mon.fail_cnt);
		if (timed_out || mon.fail_cnt != 0)
			$display("SIMULATION FAILED");
		else
			$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/lcd_monitor.sv ====
`default_nettype none

module lcd_monitor (
	input wire       qzt_clk,
	input wire       reset,
	input wire       lcd_rs,
	input wire       lcd_e,
	input wire [3:0] lcd_data
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int STARTUP_TIMEOUT = 3000;
	localparam int FRAME_TIMEOUT   = 2000;
	localparam logic [15:0] WAKE_NIBS   = 16'h3332;
	localparam logic [31:0] CONFIG_CMDS = 32'h28_06_0C_01;

	logic [4:0] nib_q [$];  // {rs, nibble}, wake-up only
	logic [8:0] byte_q [$]; // {rs, byte}
	logic       e_prev     = 1'b0;
	logic       have_upper = 1'b0;
	logic [4:0] upper;
	int         pass_cnt = 0;
	int         fail_cnt = 0;

	// Pins are sampled away from the active edge
	always @(negedge qzt_clk) begin
		if (!reset && e_prev && !lcd_e) begin
			if (nib_q.size() < 4) begin
				nib_q.push_back({lcd_rs, lcd_data});
			end else if (!have_upper) begin
				upper      = {lcd_rs, lcd_data};
				have_upper = 1'b1;
			end else begin
				byte_q.push_back({upper, lcd_data});
				have_upper = 1'b0;
			end
		end
		e_prev = reset ? 1'b0 : lcd_e;
	end

	task automatic report(input bit ok, input string name);
		if (ok)
			pass_cnt++;
		else
			fail_cnt++;
		$display("%s: %s", ok ? "PASS" : "FAIL", name);
	endtask

	task automatic check_idle(input string name);
		bit ok;
		ok = !lcd_e && !lcd_rs && lcd_data == 4'h0;
		if (!ok)
			$display("[ERROR] %0t: pins not idle, e %b rs %b data %h", $time,
				lcd_e, lcd_rs, lcd_data);
		report(ok, name);
	endtask

	task automatic check_startup(output bit timed_out);
		int cycles;
		bit ok;
		timed_out = 1'b0;
		cycles    = 0;
		ok        = 1'b1;
		while (byte_q.size() < 4 && cycles < STARTUP_TIMEOUT) begin
			@(posedge qzt_clk);
			cycles++;
		end
		if (byte_q.size() < 4) begin
			$display("Timeout: the configuration commands never reached the LCD pins");
			timed_out = 1'b1;
			return;
		end
		for (int i = 0; i < 4; i++) begin
			if (nib_q[i] !== {1'b0, WAKE_NIBS[15-4*i -: 4]}) begin
				$display("[ERROR] %0t: wake-up nibble %0d is %h", $time, i, nib_q[i]);
				ok = 1'b0;
			end
			if (byte_q[i] !== {1'b0, CONFIG_CMDS[31-8*i -: 8]}) begin
				$display("[ERROR] %0t: command %0d is %h", $time, i, byte_q[i]);
				ok = 1'b0;
			end
		end
		report(ok, "wake-up nibbles and configuration commands");
	endtask

	// Second HOME after the call starts the frame under test
	task automatic check_frame(input logic [63:0] text, input string name,
		output bit timed_out);
		int cycles;
		int idx;
		int homes;
		int start;
		bit ok;
		logic [8:0] want;
		cycles    = 0;
		idx       = byte_q.size();
		homes     = 0;
		start     = -1;
		ok        = 1'b1;
		timed_out = 1'b0;
		while (!(start >= 0 && byte_q.size() >= start + 9) && cycles < FRAME_TIMEOUT) begin
			@(posedge qzt_clk);
			cycles++;
			while (start < 0 && idx < byte_q.size()) begin
				if (byte_q[idx] == 9'h080) begin
					homes++;
					if (homes == 2)
						start = idx;
				end
				idx++;
			end
		end
		if (start < 0 || byte_q.size() < start + 9) begin
			$display("Timeout: two complete frames did not arrive for %s", name);
			timed_out = 1'b1;
			return;
		end
		for (int k = 0; k < 8; k++) begin
			want = {1'b1, text[63-8*k -: 8]};
			if (byte_q[start+1+k] !== want) begin
				$display("[ERROR] %0t: %s char %0d got %h, expected %h", $time, name, k,
					byte_q[start+1+k], want);
				ok = 1'b0;
			end
		end
		report(ok, $sformatf("%s shows \"%s\"", name, text));
	endtask

endmodule

`default_nettype wire

// ==== hw/debug_text_formatter.sv ====
`default_nettype none

`include "lcd_debug_defs.svh"

module debug_text_formatter (
	input  wire [2:0]                char_pos,
	input  wire                      ram_view,
	input  wire [7:0]                mem_addr,
	input  wire [7:0]                mem_data,
	input  wire [95:0]               cpu_regs,
	input  wire [3:0]                reg_sel,
	output lcd_debug_pkg::lcd_char_u char_byte
);
	logic [7:0]  reg_val;
	logic [15:0] reg_name;
	logic [15:0] mid_pair; // Positions 3 and 4
	logic [7:0]  shown_val;

	// 0-9 to '0'-'9', 10-15 to 'A'-'F'
	function automatic logic [7:0] hex_char(input logic [3:0] v);
		return (v <= 4'd9) ? {4'h3, v} : 8'h37 + {4'h0, v};
	endfunction

	assign reg_val = (reg_sel < 4'(`LCD_REG_COUNT)) ? cpu_regs[{reg_sel, 3'b000} +: 8] : 8'h00;

	always_comb begin
		case (reg_sel)
			4'd0:    reg_name = "PC";
			4'd1:    reg_name = "IR";
			4'd2:    reg_name = "ST";
			4'd3:    reg_name = "W ";
			4'd4:    reg_name = "Z ";
			4'd5:    reg_name = "A ";
			4'd6:    reg_name = "B ";
			4'd7:    reg_name = "C ";
			4'd8:    reg_name = "SP";
			4'd9:    reg_name = "AD"; // Address bus
			4'd10:   reg_name = "DO";
			4'd11:   reg_name = "DI";
			default: reg_name = "  "; // No such register
		endcase
	end

	assign mid_pair  = ram_view ? {hex_char(mem_addr[7:4]), hex_char(mem_addr[3:0])} : reg_name;
	assign shown_val = ram_view ? mem_data : reg_val;

	always_comb begin
		case (char_pos)
			3'd0:    char_byte.full = ram_view ? "R" : "P";
			3'd1:    char_byte.full = ram_view ? "M" : "C";
			3'd3:    char_byte.full = mid_pair[15:8];
			3'd4:    char_byte.full = mid_pair[7:0];
			3'd6:    char_byte.full = hex_char(shown_val[7:4]);
			3'd7:    char_byte.full = hex_char(shown_val[3:0]);
			default: char_byte.full = " "; // Separators
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/lcd_byte_if.sv ====
`default_nettype none

interface lcd_byte_if ();
	import lcd_debug_pkg::*;

	logic      valid;  // Byte offered
	logic      rs;     // 0 command, 1 data
	logic      single; // Upper nibble only
	lcd_char_u data;
	logic      ready;  // Writer free

	modport sequencer (output valid, rs, single, data, input ready);
	modport writer (input valid, rs, single, data, output ready);

endinterface

`default_nettype wire

// ==== hw/lcd_debug_defs.svh ====
`ifndef LCD_DEBUG_DEFS_SVH
`define LCD_DEBUG_DEFS_SVH

// Timing defaults in clock cycles
`define LCD_STEP_CYCLES      16
`define LCD_HOLD_CYCLES      4096
`define LCD_POWER_ON_CYCLES  753664
`define LCD_WAKE_CYCLES      212960
`define LCD_CLEAR_CYCLES     98304
`define LCD_FRAME_CYCLES     65536

// Controller command bytes
`define LCD_CMD_FUNCTION     8'h28
`define LCD_CMD_ENTRY        8'h06
`define LCD_CMD_DISPLAY      8'h0C
`define LCD_CMD_CLEAR        8'h01
`define LCD_CMD_HOME         8'h80

// Line layout and register bus
`define LCD_LINE_CHARS       8
`define LCD_REG_COUNT        12

`endif

// ==== hw/lcd_debug_pkg.sv ====
`default_nettype none

package lcd_debug_pkg;

	// One byte for the LCD, filled as a whole and sent as two nibbles
	typedef union packed {
		logic [7:0] full;
		struct packed {
			logic [3:0] upper; // Goes out first
			logic [3:0] lower;
		} nib;
	} lcd_char_u;

endpackage

`default_nettype wire

// ==== hw/lcd_debug_top.sv ====
`default_nettype none

`include "lcd_debug_defs.svh"

module lcd_debug_top #(
	parameter int STEP     = `LCD_STEP_CYCLES,
	parameter int HOLD     = `LCD_HOLD_CYCLES,
	parameter int POWER_ON = `LCD_POWER_ON_CYCLES,
	parameter int WAKE     = `LCD_WAKE_CYCLES,
	parameter int CLEAR    = `LCD_CLEAR_CYCLES,
	parameter int FRAME    = `LCD_FRAME_CYCLES
) (
	input  wire        qzt_clk,
	input  wire        reset,
	input  wire        ram_view,
	input  wire [7:0]  mem_addr,
	input  wire [7:0]  mem_data,
	input  wire [95:0] cpu_regs,
	input  wire [3:0]  reg_sel,
	output wire        lcd_rs,
	output wire        lcd_e,
	output wire [3:0]  lcd_data
);
	import lcd_debug_pkg::*;

	logic [2:0] char_pos;
	lcd_char_u  char_byte;

	lcd_byte_if bus ();

	lcd_sequencer #(
		.POWER_ON(POWER_ON),
		.WAKE    (WAKE),
		.CLEAR   (CLEAR),
		.FRAME   (FRAME)
	) u_sequencer (
		.qzt_clk  (qzt_clk),
		.reset    (reset),
		.bus      (bus.sequencer),
		.char_pos (char_pos),
		.char_byte(char_byte)
	);

	debug_text_formatter u_formatter (
		.char_pos (char_pos),
		.ram_view (ram_view),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.cpu_regs (cpu_regs),
		.reg_sel  (reg_sel),
		.char_byte(char_byte)
	);

	lcd_nibble_writer #(
		.STEP(STEP),
		.HOLD(HOLD)
	) u_writer (
		.qzt_clk (qzt_clk),
		.reset   (reset),
		.bus     (bus.writer),
		.lcd_rs  (lcd_rs),
		.lcd_e   (lcd_e),
		.lcd_data(lcd_data)
	);

endmodule

`default_nettype wire

// ==== hw/lcd_nibble_writer.sv ====
`default_nettype none

`include "lcd_debug_defs.svh"

module lcd_nibble_writer #(
	parameter int STEP = `LCD_STEP_CYCLES,
	parameter int HOLD = `LCD_HOLD_CYCLES
) (
	input  wire        qzt_clk,
	input  wire        reset,
	lcd_byte_if.writer bus,
	output logic       lcd_rs,
	output logic       lcd_e,
	output logic [3:0] lcd_data
);
	localparam int CW = $clog2(HOLD + 1);

	// Event cycles, counted from the accepting clock
	localparam logic [CW-1:0] E1_RISE  = CW'(STEP);
	localparam logic [CW-1:0] E1_FALL  = CW'(2 * STEP);
	localparam logic [CW-1:0] LO_SETUP = CW'(6 * STEP);
	localparam logic [CW-1:0] E2_RISE  = CW'(7 * STEP);
	localparam logic [CW-1:0] E2_FALL  = CW'(8 * STEP);
	localparam logic [CW-1:0] DONE     = CW'(HOLD);

	logic [CW-1:0] cnt;
	logic [CW-1:0] cnt_nxt;
	logic          ready_q;
	logic          single_q;
	logic [3:0]    lower_q;
	logic          accept;

	assign bus.ready = ready_q;
	assign accept    = bus.valid && ready_q;
	assign cnt_nxt   = cnt + 1'b1;

	// Second half of the byte, kept for later
	always_ff @(posedge qzt_clk) begin
		if (accept) begin
			single_q <= bus.single;
			lower_q  <= bus.data.nib.lower;
		end
	end

	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			cnt      <= '0;
			ready_q  <= 1'b1;
			lcd_rs   <= 1'b0;
			lcd_e    <= 1'b0;
			lcd_data <= 4'h0;
		end else if (ready_q) begin
			if (accept) begin
				ready_q  <= 1'b0;
				cnt      <= CW'(1);
				lcd_rs   <= bus.rs;
				lcd_data <= bus.data.nib.upper; // Visible in cycle 1
			end
		end else begin
			cnt <= cnt_nxt;
			if (cnt_nxt == E1_RISE)
				lcd_e <= 1'b1;
			if (cnt_nxt == E1_FALL)
				lcd_e <= 1'b0;
			// Wake-up nibbles stop after the first pulse
			if (!single_q) begin
				if (cnt_nxt == LO_SETUP)
					lcd_data <= lower_q;
				if (cnt_nxt == E2_RISE)
					lcd_e <= 1'b1;
				if (cnt_nxt == E2_FALL)
					lcd_e <= 1'b0;
			end
			if (cnt_nxt == DONE) begin
				ready_q  <= 1'b1; // Controller had time to execute
				lcd_data <= 4'h0;
			end
		end
	end

	a_pins_stable: assert property (@(posedge qzt_clk) disable iff (reset)
		lcd_e |=> !lcd_e || ($stable(lcd_data) && $stable(lcd_rs)))
		else $error("lcd_data or lcd_rs changed while lcd_e was high");

	a_e_low_in_reset: assert property (@(posedge qzt_clk)
		reset |=> !lcd_e)
		else $error("lcd_e high after a reset cycle");

endmodule

`default_nettype wire

// ==== hw/lcd_sequencer.sv ====
`default_nettype none

`include "lcd_debug_defs.svh"

module lcd_sequencer #(
	parameter int POWER_ON = `LCD_POWER_ON_CYCLES,
	parameter int WAKE     = `LCD_WAKE_CYCLES,
	parameter int CLEAR    = `LCD_CLEAR_CYCLES,
	parameter int FRAME    = `LCD_FRAME_CYCLES
) (
	input  wire                           qzt_clk,
	input  wire                           reset,
	lcd_byte_if.sequencer                 bus,
	output logic [2:0]                    char_pos,
	input  wire lcd_debug_pkg::lcd_char_u char_byte
);
	import lcd_debug_pkg::*;

	localparam logic [1:0] PH_WAKE    = 2'd0;
	localparam logic [1:0] PH_CONFIG  = 2'd1;
	localparam logic [1:0] PH_REFRESH = 2'd2;

	// Sum covers the longest of the waits
	localparam int WW = $clog2(POWER_ON + WAKE + CLEAR + FRAME + 1);
	localparam logic [3:0] LAST_CHAR = 4'(`LCD_LINE_CHARS);

	logic [1:0]    phase;
	logic [3:0]    step;     // Nibble, command or frame position
	logic          waiting;
	logic [WW-1:0] wait_cnt;
	logic          accept;
	logic          rs_w;
	logic          single_w;
	lcd_char_u     data_w;

	assign accept     = bus.valid && bus.ready;
	assign bus.valid  = !waiting;
	assign bus.rs     = rs_w;
	assign bus.single = single_w;
	assign bus.data   = data_w;
	assign char_pos   = 3'(step - 4'd1); // Step 0 is the HOME command

	always_comb begin
		rs_w        = 1'b0;
		single_w    = 1'b0;
		data_w.full = 8'h00;
		case (phase)
			PH_WAKE: begin
				single_w         = 1'b1;
				data_w.nib.upper = (step == 4'd3) ? 4'h2 : 4'h3; // 2 switches to 4-bit bus
			end
			PH_CONFIG: begin
				case (step[1:0])
					2'd0:    data_w.full = `LCD_CMD_FUNCTION;
					2'd1:    data_w.full = `LCD_CMD_ENTRY;
					2'd2:    data_w.full = `LCD_CMD_DISPLAY;
					default: data_w.full = `LCD_CMD_CLEAR;
				endcase
			end
			default: begin
				if (step == 4'd0) begin
					data_w.full = `LCD_CMD_HOME;
				end else begin
					rs_w   = 1'b1;
					data_w = char_byte;
				end
			end
		endcase
	end

	// Waits only run while the writer is idle
	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			phase    <= PH_WAKE;
			step     <= 4'd0;
			waiting  <= 1'b1;
			wait_cnt <= WW'(POWER_ON - 1);
		end else if (waiting) begin
			if (bus.ready) begin
				if (wait_cnt == '0)
					waiting <= 1'b0;
				else
					wait_cnt <= wait_cnt - 1'b1;
			end
		end else if (accept) begin
			step <= step + 4'd1;
			case (phase)
				PH_WAKE: begin
					waiting  <= 1'b1;
					wait_cnt <= WW'(WAKE - 1);
					if (step == 4'd3) begin
						phase <= PH_CONFIG;
						step  <= 4'd0;
					end
				end
				PH_CONFIG: begin
					if (step == 4'd3) begin // Clear was the last one
						phase    <= PH_REFRESH;
						step     <= 4'd0;
						waiting  <= 1'b1;
						wait_cnt <= WW'(CLEAR - 1);
					end
				end
				default: begin
					if (step == LAST_CHAR) begin
						step     <= 4'd0;
						waiting  <= 1'b1;
						wait_cnt <= WW'(FRAME - 1);
					end
				end
			endcase
		end
	end

	a_payload_held: assert property (@(posedge qzt_clk) disable iff (reset)
		bus.valid && !bus.ready |=> bus.valid && $stable(bus.rs) && $stable(bus.single)
			&& $stable(bus.data))
		else $error("payload dropped or changed before the writer took it");

	a_pos_range: assert property (@(posedge qzt_clk) disable iff (reset)
		bus.valid && bus.rs |-> (step - 4'd1) < LAST_CHAR)
		else $error("character position past the end of the line");

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/lcd_debug_pkg.sv
hw/lcd_byte_if.sv
hw/lcd_nibble_writer.sv
hw/lcd_sequencer.sv
hw/debug_text_formatter.sv
hw/lcd_debug_top.sv
dv/lcd_monitor.sv
dv/lcd_debug_tb.sv
